// ==== hw/axil_cpuif.sv ====
module axil_cpuif import tcp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    output logic                   awready,
    input  logic                   awvalid,
    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic [2:0]             awprot,
    output logic                   wready,
    input  logic                   wvalid,
    input  logic [DATA_W-1:0]      wdata,
    input  logic [DATA_W/8-1:0]    wstrb,
    input  logic                   bready,
    output logic                   bvalid,
    output logic [1:0]             bresp,
    output logic                   arready,
    input  logic                   arvalid,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    input  logic [2:0]             arprot,
    input  logic                   rready,
    output logic                   rvalid,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,

    output logic                   req,
    output logic                   req_is_wr,
    output reg_addr_u              addr,
    output logic [DATA_W-1:0]      wr_data,
    output logic [DATA_W-1:0]      wr_biten,
    input  logic                   rd_ack,
    input  logic                   rd_err,
    input  logic [DATA_W-1:0]      rd_data,
    input  logic                   wr_ack,
    input  logic                   wr_err
);

    logic [1:0]          state;
    logic                wr_start;
    logic                rd_start;
    logic [DATA_W-1:0]   strb_bits;

    // a write needs both address and data, and beats a read arriving in the same cycle
    assign wr_start = (state == ST_IDLE) && awvalid && wvalid;
    assign rd_start = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_start;
    assign wready = wr_start;
    assign arready = rd_start;

    always_comb begin
        for (int i = 0; i < DATA_W / 8; i++) begin
            strb_bits[i*8 +: 8] = {8{wstrb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            req <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_start || rd_start) begin
                        state <= ST_REQ;
                        req <= 1'b1;
                    end
                end
                ST_REQ: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (req_is_wr && wr_ack) begin
                        bvalid <= 1'b1;
                        state <= ST_RESP;
                    end else if (!req_is_wr && rd_ack) begin
                        rvalid <= 1'b1;
                        state <= ST_RESP;
                    end
                end
                default: begin
                    // response is held here until the host takes it
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state <= ST_IDLE;
                    end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            req_is_wr <= 1'b1;
            addr.flat <= awaddr;
            wr_data <= wdata;
            wr_biten <= strb_bits;
        end else if (rd_start) begin
            req_is_wr <= 1'b0;
            addr.flat <= araddr;
        end
        if (state == ST_WAIT && wr_ack) begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (state == ST_WAIT && rd_ack) begin
            rdata <= rd_data;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

    assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    assert property (@(posedge clk) disable iff (reset)
        req |-> state == ST_REQ);

endmodule

// ==== hw/tcp.sv ====
module tcp import tcp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    output logic                   s_reg_axil_awready,
    input  logic                   s_reg_axil_awvalid,
    input  logic [AXIL_ADDR_W-1:0] s_reg_axil_awaddr,
    input  logic [2:0]             s_reg_axil_awprot,
    output logic                   s_reg_axil_wready,
    input  logic                   s_reg_axil_wvalid,
    input  logic [DATA_W-1:0]      s_reg_axil_wdata,
    input  logic [DATA_W/8-1:0]    s_reg_axil_wstrb,
    input  logic                   s_reg_axil_bready,
    output logic                   s_reg_axil_bvalid,
    output logic [1:0]             s_reg_axil_bresp,
    output logic                   s_reg_axil_arready,
    input  logic                   s_reg_axil_arvalid,
    input  logic [AXIL_ADDR_W-1:0] s_reg_axil_araddr,
    input  logic [2:0]             s_reg_axil_arprot,
    input  logic                   s_reg_axil_rready,
    output logic                   s_reg_axil_rvalid,
    output logic [DATA_W-1:0]      s_reg_axil_rdata,
    output logic [1:0]             s_reg_axil_rresp
);

    logic [NUM_TCP-1:0]    stream_req;
    logic                  req_is_wr;
    logic [WIN_ADDR_W-1:0] offset;
    logic [DATA_W-1:0]     wr_data;
    logic [DATA_W-1:0]     wr_biten;
    logic [NUM_TCP-1:0]    stream_rd_ack, stream_rd_err;
    logic [NUM_TCP-1:0]    stream_wr_ack, stream_wr_err;
    logic [NUM_TCP-1:0]    stream_enabled;
    logic [DATA_W-1:0]     stream_rd_data [NUM_TCP];

    tcp_top_regfile u_tcp_top_regfile (
        .clk(clk), .reset(reset),
        .awready(s_reg_axil_awready), .awvalid(s_reg_axil_awvalid),
        .awaddr(s_reg_axil_awaddr), .awprot(s_reg_axil_awprot),
        .wready(s_reg_axil_wready), .wvalid(s_reg_axil_wvalid),
        .wdata(s_reg_axil_wdata), .wstrb(s_reg_axil_wstrb),
        .bready(s_reg_axil_bready), .bvalid(s_reg_axil_bvalid), .bresp(s_reg_axil_bresp),
        .arready(s_reg_axil_arready), .arvalid(s_reg_axil_arvalid),
        .araddr(s_reg_axil_araddr), .arprot(s_reg_axil_arprot),
        .rready(s_reg_axil_rready), .rvalid(s_reg_axil_rvalid),
        .rdata(s_reg_axil_rdata), .rresp(s_reg_axil_rresp),
        .stream_req(stream_req), .req_is_wr(req_is_wr), .offset(offset),
        .wr_data(wr_data), .wr_biten(wr_biten),
        .stream_rd_ack(stream_rd_ack), .stream_rd_err(stream_rd_err),
        .stream_rd_data(stream_rd_data),
        .stream_wr_ack(stream_wr_ack), .stream_wr_err(stream_wr_err),
        .stream_enabled(stream_enabled)
    );

    for (genvar i = 0; i < NUM_TCP; i++) begin : g_stream
        tcp_stream u_tcp_stream (
            .clk(clk), .reset(reset),
            .req(stream_req[i]), .req_is_wr(req_is_wr), .offset(offset),
            .wr_data(wr_data), .wr_biten(wr_biten),
            .rd_ack(stream_rd_ack[i]), .rd_err(stream_rd_err[i]),
            .rd_data(stream_rd_data[i]),
            .wr_ack(stream_wr_ack[i]), .wr_err(stream_wr_err[i]),
            .enabled(stream_enabled[i])
        );
    end

endmodule

// ==== hw/tcp_pkg.sv ====
package tcp_pkg;

    localparam int NUM_TCP = 7;
    localparam int AXIL_ADDR_W = 9;
    localparam int DATA_W = 32;
    localparam int WIN_ADDR_W = 6;
    localparam int WIN_W = AXIL_ADDR_W - WIN_ADDR_W;  // window 0 is global, 1 to 7 are streams

    localparam logic [DATA_W-1:0] TCP_ID_VALUE = 32'h7C90_0001;

    // window 0 word offsets
    localparam logic [WIN_ADDR_W-1:0] REG_ID = 6'h00;
    localparam logic [WIN_ADDR_W-1:0] REG_SCRATCH = 6'h04;
    localparam logic [WIN_ADDR_W-1:0] REG_ENABLE_MASK = 6'h08;

    // stream window word offsets
    localparam logic [WIN_ADDR_W-1:0] REG_CTRL = 6'h00;
    localparam logic [WIN_ADDR_W-1:0] REG_PORTS = 6'h04;
    localparam logic [WIN_ADDR_W-1:0] REG_REMOTE_IP = 6'h08;
    localparam logic [WIN_ADDR_W-1:0] REG_SEQ_NUM = 6'h0C;
    localparam logic [WIN_ADDR_W-1:0] REG_SEQ_ADVANCE = 6'h10;
    localparam logic [WIN_ADDR_W-1:0] REG_ADVANCE_COUNT = 6'h14;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // bus interface FSM states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    typedef union packed {
        logic [AXIL_ADDR_W-1:0] flat;  // byte offset as seen on the bus
        struct packed {
            logic [WIN_W-1:0]      win;
            logic [WIN_ADDR_W-1:0] offset;
        } window;
    } reg_addr_u;

    function automatic logic [DATA_W-1:0] merge_biten(input logic [DATA_W-1:0] old_val,
                                                     input logic [DATA_W-1:0] new_val,
                                                     input logic [DATA_W-1:0] biten);
        return (old_val & ~biten) | (new_val & biten);
    endfunction

endpackage

// ==== hw/tcp_stream.sv ====
module tcp_stream import tcp_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  req,
    input  logic                  req_is_wr,
    input  logic [WIN_ADDR_W-1:0] offset,
    input  logic [DATA_W-1:0]     wr_data,
    input  logic [DATA_W-1:0]     wr_biten,

    output logic                  rd_ack,
    output logic                  rd_err,
    output logic [DATA_W-1:0]     rd_data,
    output logic                  wr_ack,
    output logic                  wr_err,
    output logic                  enabled
);

    logic              ctrl_en;
    logic [15:0]       local_port;
    logic [15:0]       remote_port;
    logic [DATA_W-1:0] remote_ip;
    logic [DATA_W-1:0] seq_num;
    logic [DATA_W-1:0] adv_count;
    logic [DATA_W-1:0] rd_word;
    logic              rd_bad;
    logic              wr_bad;
    logic              wr_hit;
    logic [DATA_W-1:0] adv_amount;

    assign enabled = ctrl_en;
    assign wr_hit = req && req_is_wr;
    assign adv_amount = wr_data & wr_biten;  // unstrobed bytes add nothing

    always_comb begin
        rd_word = '0;
        rd_bad = 1'b0;
        wr_bad = 1'b0;
        case (offset)
            REG_CTRL: rd_word = {{(DATA_W-1){1'b0}}, ctrl_en};
            REG_PORTS: rd_word = {local_port, remote_port};
            REG_REMOTE_IP: rd_word = remote_ip;
            REG_SEQ_NUM: rd_word = seq_num;
            REG_SEQ_ADVANCE: rd_word = '0;  // write-only trigger
            REG_ADVANCE_COUNT: begin
                rd_word = adv_count;
                wr_bad = 1'b1;
            end
            default: begin
                rd_bad = 1'b1;
                wr_bad = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_en <= 1'b0;
            local_port <= '0;
            remote_port <= '0;
            remote_ip <= '0;
            seq_num <= '0;
            adv_count <= '0;
            rd_ack <= 1'b0;
            wr_ack <= 1'b0;
        end else begin
            rd_ack <= req && !req_is_wr;
            wr_ack <= wr_hit;
            if (wr_hit) begin
                case (offset)
                    REG_CTRL: begin
                        ctrl_en <= (ctrl_en & ~wr_biten[0]) | (wr_data[0] & wr_biten[0]);
                    end
                    REG_PORTS: begin
                        {local_port, remote_port} <=
                            merge_biten({local_port, remote_port}, wr_data, wr_biten);
                    end
                    REG_REMOTE_IP: remote_ip <= merge_biten(remote_ip, wr_data, wr_biten);
                    REG_SEQ_NUM: seq_num <= merge_biten(seq_num, wr_data, wr_biten);
                    REG_SEQ_ADVANCE: begin
                        // a disabled stream acks the advance but keeps its state
                        if (ctrl_en) begin
                            seq_num <= seq_num + adv_amount;
                            adv_count <= adv_count + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rd_data <= req_is_wr ? '0 : rd_word;
            rd_err <= rd_bad;
            wr_err <= wr_bad;
        end
    end

    // every request is answered by exactly one ack in the next cycle
    assert property (@(posedge clk) disable iff (reset)
        req |=> (rd_ack ^ wr_ack));

endmodule

// ==== hw/tcp_top_regfile.sv ====
module tcp_top_regfile import tcp_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    output logic                   awready,
    input  logic                   awvalid,
    input  logic [AXIL_ADDR_W-1:0] awaddr,
    input  logic [2:0]             awprot,
    output logic                   wready,
    input  logic                   wvalid,
    input  logic [DATA_W-1:0]      wdata,
    input  logic [DATA_W/8-1:0]    wstrb,
    input  logic                   bready,
    output logic                   bvalid,
    output logic [1:0]             bresp,
    output logic                   arready,
    input  logic                   arvalid,
    input  logic [AXIL_ADDR_W-1:0] araddr,
    input  logic [2:0]             arprot,
    input  logic                   rready,
    output logic                   rvalid,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,

    output logic [NUM_TCP-1:0]     stream_req,
    output logic                   req_is_wr,
    output logic [WIN_ADDR_W-1:0]  offset,
    output logic [DATA_W-1:0]      wr_data,
    output logic [DATA_W-1:0]      wr_biten,
    input  logic [NUM_TCP-1:0]     stream_rd_ack,
    input  logic [NUM_TCP-1:0]     stream_rd_err,
    input  logic [DATA_W-1:0]      stream_rd_data [NUM_TCP],
    input  logic [NUM_TCP-1:0]     stream_wr_ack,
    input  logic [NUM_TCP-1:0]     stream_wr_err,
    input  logic [NUM_TCP-1:0]     stream_enabled
);

    logic              req;
    reg_addr_u         addr;
    logic [WIN_W-1:0]  win;
    logic              glob_sel;
    logic              rd_ack, rd_err, wr_ack, wr_err;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] scratch;
    logic              glob_rd_ack, glob_wr_ack;
    logic              glob_rd_err, glob_wr_err;
    logic [DATA_W-1:0] glob_rd_data;
    logic [DATA_W-1:0] glob_word;
    logic              glob_rd_bad, glob_wr_bad;

    axil_cpuif u_axil_cpuif (
        .clk(clk), .reset(reset),
        .awready(awready), .awvalid(awvalid), .awaddr(awaddr), .awprot(awprot),
        .wready(wready), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
        .bready(bready), .bvalid(bvalid), .bresp(bresp),
        .arready(arready), .arvalid(arvalid), .araddr(araddr), .arprot(arprot),
        .rready(rready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
        .req(req), .req_is_wr(req_is_wr), .addr(addr),
        .wr_data(wr_data), .wr_biten(wr_biten),
        .rd_ack(rd_ack), .rd_err(rd_err), .rd_data(rd_data),
        .wr_ack(wr_ack), .wr_err(wr_err)
    );

    assign win = addr.window.win;
    assign offset = addr.window.offset;
    assign glob_sel = req && (win == '0);

    always_comb begin
        for (int i = 0; i < NUM_TCP; i++) begin
            stream_req[i] = req && (win == WIN_W'(i + 1));  // stream i lives in window i+1
        end
    end

    always_comb begin
        glob_word = '0;
        glob_rd_bad = 1'b0;
        glob_wr_bad = 1'b0;
        case (offset)
            REG_ID: begin
                glob_word = TCP_ID_VALUE;
                glob_wr_bad = 1'b1;
            end
            REG_SCRATCH: glob_word = scratch;
            REG_ENABLE_MASK: begin
                glob_word = {{(DATA_W-NUM_TCP){1'b0}}, stream_enabled};
                glob_wr_bad = 1'b1;
            end
            default: begin
                glob_rd_bad = 1'b1;
                glob_wr_bad = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch <= '0;
            glob_rd_ack <= 1'b0;
            glob_wr_ack <= 1'b0;
        end else begin
            glob_rd_ack <= glob_sel && !req_is_wr;
            glob_wr_ack <= glob_sel && req_is_wr;
            if (glob_sel && req_is_wr && offset == REG_SCRATCH) begin
                scratch <= merge_biten(scratch, wr_data, wr_biten);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (glob_sel) begin
            glob_rd_data <= glob_word;
            glob_rd_err <= glob_rd_bad;
            glob_wr_err <= glob_wr_bad;
        end
    end

    // only one source acks per request, so the responses can be or-ed together
    always_comb begin
        rd_ack = glob_rd_ack;
        wr_ack = glob_wr_ack;
        rd_err = glob_rd_ack && glob_rd_err;
        wr_err = glob_wr_ack && glob_wr_err;
        rd_data = glob_rd_ack ? glob_rd_data : '0;
        for (int i = 0; i < NUM_TCP; i++) begin
            rd_ack = rd_ack | stream_rd_ack[i];
            wr_ack = wr_ack | stream_wr_ack[i];
            rd_err = rd_err | (stream_rd_ack[i] & stream_rd_err[i]);
            wr_err = wr_err | (stream_wr_ack[i] & stream_wr_err[i]);
            if (stream_rd_ack[i]) begin
                rd_data = rd_data | stream_rd_data[i];
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(stream_req));

endmodule

// ==== list.f ====
hw/tcp_pkg.sv
hw/axil_cpuif.sv
hw/tcp_stream.sv
hw/tcp_top_regfile.sv
hw/tcp.sv
tb/tcp_tb.sv

// ==== tb/tcp_tb.sv ====
module tcp_tb import tcp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   reset;
    logic                   awready, awvalid, wready, wvalid, bready, bvalid;
    logic                   arready, arvalid, rready, rvalid;
    logic [AXIL_ADDR_W-1:0] awaddr, araddr;
    logic [DATA_W-1:0]      wdata, rdata;
    logic [DATA_W/8-1:0]    wstrb;
    logic [1:0]             bresp, rresp;

    logic [DATA_W-1:0] m_scratch;
    logic [DATA_W-1:0] m_reg [NUM_TCP][6];  // ctrl, ports, remote ip, seq, advance, count
    string             q_name [$];
    logic [DATA_W-1:0] q_got [$];
    logic [DATA_W-1:0] q_exp [$];
    int                n_checks = 0;
    int                n_errors = 0;
    int                test_errors = 0;
    int                n_trans = 0;
    int                cycles = 0;
    logic [1:0]        resp;
    logic [DATA_W-1:0] rd;

    tcp tcp_inst (
        .clk(clk), .reset(reset),
        .s_reg_axil_awready(awready), .s_reg_axil_awvalid(awvalid),
        .s_reg_axil_awaddr(awaddr), .s_reg_axil_awprot(3'd0),
        .s_reg_axil_wready(wready), .s_reg_axil_wvalid(wvalid),
        .s_reg_axil_wdata(wdata), .s_reg_axil_wstrb(wstrb),
        .s_reg_axil_bready(bready), .s_reg_axil_bvalid(bvalid), .s_reg_axil_bresp(bresp),
        .s_reg_axil_arready(arready), .s_reg_axil_arvalid(arvalid),
        .s_reg_axil_araddr(araddr), .s_reg_axil_arprot(3'd0),
        .s_reg_axil_rready(rready), .s_reg_axil_rvalid(rvalid),
        .s_reg_axil_rdata(rdata), .s_reg_axil_rresp(rresp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * n_trans + 200) begin
            $display("timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // expected {resp, data} of one access, and the model update for a write
    function automatic logic [33:0] ref_access(input bit wr, input logic [8:0] a,
                                               input logic [31:0] d, input logic [3:0] s);
        logic [31:0] m;
        logic [31:0] mask;
        int w;
        int k;
        for (int i = 0; i < 4; i++)
            m[i*8 +: 8] = {8{s[i]}};
        mask = '0;
        for (int i = 0; i < NUM_TCP; i++)
            mask[i] = m_reg[i][0][0];
        w = a[8:6];
        k = a[4:2];
        if (w == 0) begin
            case (a[5:0])
                REG_ID: return wr ? {RESP_SLVERR, 32'h0} : {RESP_OKAY, TCP_ID_VALUE};
                REG_SCRATCH: begin
                    if (wr)
                        m_scratch = (m_scratch & ~m) | (d & m);
                    return {RESP_OKAY, wr ? 32'h0 : m_scratch};
                end
                REG_ENABLE_MASK: return wr ? {RESP_SLVERR, 32'h0} : {RESP_OKAY, mask};
                default: return {RESP_SLVERR, 32'h0};
            endcase
        end
        if (a[1:0] != 2'b00 || a[5:0] > REG_ADVANCE_COUNT)
            return {RESP_SLVERR, 32'h0};
        if (!wr)
            return {RESP_OKAY, m_reg[w-1][k]};
        if (k == 5)
            return {RESP_SLVERR, 32'h0};
        if (k == 4 && m_reg[w-1][0][0]) begin
            m_reg[w-1][3] = m_reg[w-1][3] + (d & m);  // wraps modulo 2^32
            m_reg[w-1][5] = m_reg[w-1][5] + 1;
        end else if (k < 4) begin
            m_reg[w-1][k] = ((m_reg[w-1][k] & ~m) | (d & m)) & (k == 0 ? 32'h1 : 32'hFFFF_FFFF);
        end
        return {RESP_OKAY, 32'h0};
    endfunction

    function automatic logic [8:0] stream_addr(input int s, input logic [5:0] off);
        return {3'(s + 1), off};
    endfunction

    task automatic push_check(input string name, input logic [31:0] got, input logic [31:0] exp);
        q_name.push_back(name);
        q_got.push_back(got);
        q_exp.push_back(exp);
    endtask

    always begin
        wait (q_name.size() > 0);
        n_checks++;
        if (q_got[0] !== q_exp[0]) begin
            $display("Fail at %0d ns: %s is %h, expected %h",
                     $time, q_name[0], q_got[0], q_exp[0]);
            n_errors++;
            test_errors++;
        end
        q_name.delete(0);
        q_got.delete(0);
        q_exp.delete(0);
    end

    task automatic end_test(input string name);
        wait (q_name.size() == 0);
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    // waits for the response and keeps it stalled for hold cycles before taking it
    task automatic hold_response(input int hold, input bit is_wr,
                                 output logic [1:0] resp_out, output logic [31:0] data);
        @(negedge clk);
        while (!(is_wr ? bvalid : rvalid))
            @(negedge clk);
        resp_out = is_wr ? bresp : rresp;
        data = rdata;
        repeat (hold) begin
            @(negedge clk);
            if (is_wr) begin
                push_check("bvalid", bvalid, 1);
                push_check("bresp", bresp, resp_out);
            end else begin
                push_check("rvalid", rvalid, 1);
                push_check("rresp", rresp, resp_out);
            end
            push_check("rdata", rdata, data);
            push_check("arready", arready, 0);  // nothing new is accepted while stalled
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            bready = is_wr;
            rready = !is_wr;
        end
        @(posedge clk);
        #1;
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic axil_write(input logic [8:0] a, input logic [31:0] d, input logic [3:0] s,
                              input int hold, output logic [1:0] resp_out);
        logic [33:0] exp;
        logic [31:0] unused;
        exp = ref_access(1'b1, a, d, s);
        n_trans++;
        awaddr = a;
        wdata = d;
        wstrb = s;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = (hold == 0);
        @(negedge clk);
        while (!awready)
            @(negedge clk);
        push_check("wready", wready, 1);  // data is taken in the same cycle as the address
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        hold_response(hold, 1'b1, resp_out, unused);
        push_check("bresp", resp_out, exp[33:32]);
    endtask

    task automatic axil_read(input logic [8:0] a, input int hold, output logic [31:0] data);
        logic [33:0] exp;
        logic [1:0]  r;
        exp = ref_access(1'b0, a, 32'h0, 4'h0);
        n_trans++;
        araddr = a;
        arvalid = 1'b1;
        rready = (hold == 0);
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        hold_response(hold, 1'b0, r, data);
        push_check("rresp", r, exp[33:32]);
        push_check("rdata", data, exp[31:0]);
    endtask

    initial begin
        void'($urandom(14));
        reset = 1'b1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = '0;
        m_scratch = '0;
        foreach (m_reg[i, j])
            m_reg[i][j] = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        axil_read({3'd0, REG_ID}, 0, rd);
        axil_read({3'd0, REG_SCRATCH}, 0, rd);
        axil_read({3'd0, REG_ENABLE_MASK}, 0, rd);
        for (int s = 0; s < NUM_TCP; s++)
            for (int k = 0; k < 6; k++)
                axil_read(stream_addr(s, 6'(k * 4)), 0, rd);
        end_test("reset values");

        repeat (12) begin
            axil_write({3'd0, REG_SCRATCH}, $urandom, 4'($urandom_range(0, 15)),
                       $urandom_range(0, 5), resp);
            axil_read({3'd0, REG_SCRATCH}, $urandom_range(0, 5), rd);
        end
        end_test("scratch storage");

        // all windows are written before any is read back, so cross-talk shows up
        for (int s = 0; s < NUM_TCP; s++)
            for (int k = 0; k < 4; k++)
                axil_write(stream_addr(s, 6'(k * 4)), $urandom, 4'($urandom_range(0, 15)),
                           $urandom_range(0, 5), resp);
        for (int s = 0; s < NUM_TCP; s++)
            for (int k = 0; k < 4; k++)
                axil_read(stream_addr(s, 6'(k * 4)), $urandom_range(0, 5), rd);
        axil_read({3'd0, REG_ENABLE_MASK}, 0, rd);
        end_test("stream independence");

        axil_write(stream_addr(0, REG_CTRL), 32'h1, 4'hF, 0, resp);
        axil_write(stream_addr(0, REG_SEQ_NUM), 32'hFFFF_FF00, 4'hF, 0, resp);
        axil_write(stream_addr(0, REG_SEQ_ADVANCE), 32'h0000_0200, 4'hF, 0, resp);  // wraps
        for (int s = 0; s < NUM_TCP; s++)
            repeat (4) begin
                axil_write(stream_addr(s, REG_CTRL), $urandom, 4'h1, 0, resp);
                axil_write(stream_addr(s, REG_SEQ_ADVANCE), $urandom,
                           4'($urandom_range(0, 15)), $urandom_range(0, 5), resp);
            end
        for (int s = 0; s < NUM_TCP; s++) begin
            axil_read(stream_addr(s, REG_SEQ_NUM), 0, rd);
            axil_read(stream_addr(s, REG_ADVANCE_COUNT), 0, rd);
            axil_read(stream_addr(s, REG_SEQ_ADVANCE), 0, rd);
        end
        end_test("sequence advance");

        axil_read({3'd0, 6'h0C}, 0, rd);
        axil_read({3'd0, 6'h3C}, 0, rd);
        axil_write({3'd0, 6'h01}, $urandom, 4'hF, 0, resp);
        axil_write({3'd0, REG_ID}, $urandom, 4'hF, 0, resp);
        axil_write({3'd0, REG_ENABLE_MASK}, $urandom, 4'hF, 0, resp);
        for (int s = 0; s < NUM_TCP; s++) begin
            axil_write(stream_addr(s, REG_ADVANCE_COUNT), $urandom, 4'hF, 0, resp);
            axil_write(stream_addr(s, 6'h18), $urandom, 4'hF, 0, resp);
            axil_read(stream_addr(s, 6'h3C), 0, rd);
            axil_read(stream_addr(s, 6'h02), 0, rd);
        end
        axil_read({3'd0, REG_ID}, 0, rd);
        axil_read({3'd0, REG_SCRATCH}, 0, rd);
        axil_read({3'd0, REG_ENABLE_MASK}, 0, rd);
        for (int s = 0; s < NUM_TCP; s++)
            for (int k = 0; k < 6; k++)
                axil_read(stream_addr(s, 6'(k * 4)), 0, rd);
        end_test("error responses");

        araddr = {3'd0, REG_SCRATCH};
        arvalid = 1'b1;  // this read waits behind the stalled write
        axil_write({3'd0, REG_SCRATCH}, 32'hA5C3_0F96, 4'hF, 5, resp);
        axil_read({3'd0, REG_SCRATCH}, 5, rd);
        axil_read(stream_addr(6, REG_PORTS), 4, rd);
        end_test("back-pressure");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
